// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ------------------------------
	// widths with a meaning

	// byte address on the fetch bus
	typedef logic [31:0] addr_t;
	// one bus word as returned by memory
	typedef logic [31:0] word_t;
	// one instruction parcel
	typedef logic [15:0] hword_t;
	// valid halfwords in cir or in the assembly buffer, 0 to 3
	typedef logic [1:0] level_t;
	// accepted fetches still waiting for data, 0 to 3
	typedef logic [1:0] flight_t;
	// architectural register number
	typedef logic [4:0] reg_idx_t;

	// ------------------------------
	// front-end constants

	// prefetch queue entries, power of two and at least 1
	localparam int FIFO_DEPTH = 2;
	// first fetch address out of reset
	localparam addr_t RESET_VECTOR = 32'h0000_0100;
	// limit on accepted fetches awaiting data
	localparam int MAX_IN_FLIGHT = 2;

	// one valid bit per queue entry, entry 0 is the head
	typedef logic [FIFO_DEPTH-1:0] qmask_t;

	// ------------------------------
	// bundles

	// address phase of the fetch bus
	typedef struct packed {
		addr_t addr;
		logic  vld;
	} fetch_req_t;

	// data phase strobe, no back-pressure
	typedef struct packed {
		word_t data;
		logic  vld;
	} fetch_data_t;

	// source registers of the instruction in cir next cycle
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     vld;
	} next_regs_t;

endpackage

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             flush,
	input  logic             push,
	input  fetch_pkg::word_t wdata,
	input  logic             pop,
	output fetch_pkg::word_t head,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);

	// entry 0 is always the head, words move down on pop
	fetch_pkg::word_t  mem [fetch_pkg::FIFO_DEPTH];
	// valid bits form a thermometer from entry 0 upwards
	fetch_pkg::qmask_t valid;
	fetch_pkg::qmask_t valid_push;
	fetch_pkg::qmask_t valid_next;
	// what each entry would load, upper neighbour or write data
	fetch_pkg::word_t  src [fetch_pkg::FIFO_DEPTH];

	assign head  = mem[0];
	assign empty = !valid[0];
	assign full  = valid[fetch_pkg::FIFO_DEPTH-1];
	// exactly one slot left free
	assign almost_full = (valid == ((fetch_pkg::qmask_t'(1) << (fetch_pkg::FIFO_DEPTH - 1))
		- fetch_pkg::qmask_t'(1)));

	// ------------------------------
	// occupancy

	always_comb begin
		// a push grows the thermometer by one at the bottom
		valid_push = push ? ((valid << 1) | fetch_pkg::qmask_t'(1)) : valid;
		// a pop drops one from the top
		valid_next = pop ? (valid_push >> 1) : valid_push;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (flush) begin
			// jump discards every buffered word at once
			valid <= '0;
		end else begin
			valid <= valid_next;
		end
	end

	// ------------------------------
	// storage

	always_comb begin
		// top entry has nothing above it, so it always takes wdata
		for (int i = 0; i < fetch_pkg::FIFO_DEPTH - 1; i++) begin
			src[i] = valid[i+1] ? mem[i+1] : wdata;
		end
		src[fetch_pkg::FIFO_DEPTH-1] = wdata;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < fetch_pkg::FIFO_DEPTH; i++) begin
			// empty slots catch a push, every slot shifts on pop
			if (pop || (push && !valid[i])) begin
				mem[i] <= src[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: fetch_request.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_request (
	input  logic                  clk,
	input  logic                  rst_n,
	input  fetch_pkg::addr_t      jump_target,
	input  logic                  jump_vld,
	output logic                  jump_rdy,
	output fetch_pkg::fetch_req_t mem_req,
	input  logic                  mem_rdy,
	input  logic                  mem_rsp_vld,
	input  logic                  q_full,
	input  logic                  q_almost_full,
	output logic                  jump_now,
	output logic                  flushing,
	output logic                  unaligned_pending
);

	// address phase was offered and not taken last cycle
	logic              hold;
	// keeps the bus quiet for the first cycle out of reset
	logic              holdoff;
	logic              accept;
	logic              stall;
	// next word to fetch, runs ahead of the pc
	fetch_pkg::addr_t  fetch_addr;
	fetch_pkg::flight_t pending;
	// responses still owed to fetches made before the last jump
	fetch_pkg::flight_t flush_cnt;

	// a held address phase must not change, so jumps wait for it
	assign jump_rdy = !hold;
	assign jump_now = jump_vld && jump_rdy;
	assign accept   = mem_req.vld && mem_rdy;
	assign flushing = |flush_cnt;

	// queue plus fetches in flight must never overflow
	assign stall = q_full
		|| (q_almost_full && pending != '0)
		|| pending >= fetch_pkg::flight_t'(fetch_pkg::MAX_IN_FLIGHT);

	// ------------------------------
	// address phase

	always_comb begin
		// priority is held request, then jump, then sequential
		mem_req.vld  = !holdoff && (hold || jump_vld || !stall);
		mem_req.addr = fetch_addr;
		if (!hold && jump_vld) begin
			// always a word access, halfword offset is dropped later
			mem_req.addr = {jump_target[31:2], 2'b00};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			holdoff    <= 1'b1;
			hold       <= 1'b0;
			fetch_addr <= fetch_pkg::RESET_VECTOR;
		end else begin
			holdoff <= 1'b0;
			hold    <= mem_req.vld && !mem_rdy;
			if (jump_now) begin
				// step past the target word if it went out right away
				fetch_addr <= {jump_target[31:2] + 30'(accept), 2'b00};
			end else if (accept) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ------------------------------
	// in-flight and flush tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending           <= '0;
			flush_cnt         <= '0;
			unaligned_pending <= 1'b0;
		end else begin
			pending <= pending + fetch_pkg::flight_t'(accept)
				- fetch_pkg::flight_t'(mem_rsp_vld);
			// data landing in the jump cycle itself is already dropped
			if (jump_now) begin
				flush_cnt <= pending - fetch_pkg::flight_t'(mem_rsp_vld);
			end else if (flushing && mem_rsp_vld) begin
				flush_cnt <= flush_cnt - fetch_pkg::flight_t'(1);
			end
			// target on an odd halfword, low half of first word is junk
			if (jump_now) begin
				unaligned_pending <= jump_target[1];
			end else if (mem_rsp_vld && !flushing) begin
				unaligned_pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: instr_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module instr_aligner (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   jump_now,
	input  logic                   flushing,
	input  logic                   unaligned_pending,
	input  fetch_pkg::fetch_data_t rsp,
	input  fetch_pkg::word_t       q_head,
	input  logic                   q_empty,
	output logic                   pop,
	output logic                   bypass_taken,
	output fetch_pkg::word_t       cir,
	output fetch_pkg::level_t      cir_vld,
	input  fetch_pkg::level_t      cir_use,
	input  logic                   cir_lock,
	output fetch_pkg::word_t       next_instr,
	output fetch_pkg::level_t      level_next
);

	// halfwords held in {hwbuf, cir}
	fetch_pkg::level_t buf_level;
	// spare halfword above the cir
	fetch_pkg::hword_t hwbuf;
	// first word after an odd jump went into the queue, not the cir
	logic              unaligned_q;
	logic              rsp_ok;
	logic              fetch_vld;
	logic              unaligned;
	logic              must_refill;
	fetch_pkg::word_t  fetch_data;
	fetch_pkg::level_t use_clipped;
	fetch_pkg::level_t level_no_fetch;
	// slot 0 is the lowest halfword, i.e. cir[15:0]
	fetch_pkg::hword_t [2:0] shifted;
	fetch_pkg::hword_t [2:0] merged;

	// stale responses never reach the buffer
	assign rsp_ok     = rsp.vld && !flushing;
	// queue head wins, bus data only when nothing is queued
	assign fetch_data = q_empty ? rsp.data : q_head;
	assign fetch_vld  = !q_empty || rsp_ok;
	assign unaligned  = unaligned_pending || unaligned_q;

	// after a lock the level is zero but decode may still report use
	assign use_clipped    = (buf_level != '0) ? cir_use : '0;
	assign level_no_fetch = buf_level - use_clipped;

	// room for a whole word once at most one halfword is left
	assign must_refill  = !cir_lock && !level_no_fetch[1];
	assign pop          = must_refill && !q_empty;
	assign bypass_taken = must_refill && q_empty && rsp_ok;

	// ------------------------------
	// shift and overlay

	always_comb begin
		// move leftovers down by what decode consumed
		case (use_clipped)
			2'd2:    shifted = {hwbuf, hwbuf, hwbuf};
			2'd1:    shifted = {hwbuf, hwbuf, cir[31:16]};
			default: shifted = {hwbuf, cir[31:16], cir[15:0]};
		endcase
		// fresh word lands right above whatever remains
		if (cir_lock || (level_no_fetch[1] && !unaligned)) begin
			merged = shifted;
		end else if (unaligned) begin
			// only the upper half of the target word is wanted
			merged = {shifted[2], shifted[1], fetch_data[31:16]};
		end else if (level_no_fetch[0]) begin
			merged = {fetch_data, shifted[0]};
		end else begin
			merged = {shifted[2], fetch_data};
		end
	end

	always_comb begin
		if (jump_now || flushing || cir_lock) begin
			level_next = '0;
		end else if (fetch_vld && unaligned) begin
			level_next = 2'd1;
		end else begin
			level_next = buf_level + {must_refill && fetch_vld, 1'b0} - use_clipped;
		end
	end

	// predecode looks at what the cir will hold next
	assign next_instr = merged[1:0];

	// ------------------------------
	// state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level   <= '0;
			cir_vld     <= '0;
			unaligned_q <= 1'b0;
		end else begin
			buf_level <= level_next;
			// level 3 shows as 2, the spare halfword is not in the cir
			if (!cir_lock) begin
				cir_vld <= level_next & ~(level_next >> 1);
			end
			if (jump_now || pop) begin
				unaligned_q <= 1'b0;
			end else if (unaligned_pending && rsp_ok && !bypass_taken) begin
				unaligned_q <= 1'b1;
			end
		end
	end

	// lock keeps the cir as decode saw it
	always_ff @(posedge clk) begin
		if (!cir_lock) begin
			{hwbuf, cir} <= merged;
		end
	end

endmodule

`default_nettype wire

// File: reg_predecode.sv
`timescale 1ns/100ps
`default_nettype none

module reg_predecode (
	input  fetch_pkg::word_t      next_instr,
	input  fetch_pkg::level_t     level_next,
	output fetch_pkg::next_regs_t next_regs
);

	logic       is_32bit;
	logic [2:0] funct3;

	assign is_32bit = next_instr[1:0] == 2'b11;
	// compressed opcode group sits in the top three bits
	assign funct3 = next_instr[15:13];

	// a 32-bit instruction needs both halfwords in place
	assign next_regs.vld = is_32bit ? level_next[1] : (level_next != '0);

	always_comb begin
		// default to the compressed short fields, x8 to x15
		next_regs.rs1 = {2'b01, next_instr[9:7]};
		next_regs.rs2 = {2'b01, next_instr[4:2]};
		case (next_instr[1:0])
			2'b11: begin
				next_regs.rs1 = next_instr[19:15];
				next_regs.rs2 = next_instr[24:20];
			end
			2'b00: begin
				// c.addi4spn reads sp
				if (funct3 == 3'b000) begin
					next_regs.rs1 = 5'd2;
				end
			end
			2'b01: begin
				// c.addi16sp reads sp, c.addi reads rd in place
				if (funct3 == 3'b011) begin
					next_regs.rs1 = 5'd2;
				end else if (funct3 == 3'b000) begin
					next_regs.rs1 = next_instr[11:7];
				end
			end
			default: begin
				// quadrant 2 uses the full register fields
				next_regs.rs1 = next_instr[11:7];
				next_regs.rs2 = next_instr[6:2];
				// c.lwsp and c.swsp address off sp
				if (funct3 == 3'b010 || funct3 == 3'b110) begin
					next_regs.rs1 = 5'd2;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// File: fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
	input  logic                   clk,
	input  logic                   rst_n,
	output fetch_pkg::fetch_req_t  mem_req,
	input  logic                   mem_rdy,
	input  fetch_pkg::fetch_data_t mem_rsp,
	input  fetch_pkg::addr_t       jump_target,
	input  logic                   jump_vld,
	output logic                   jump_rdy,
	output fetch_pkg::word_t       cir,
	output fetch_pkg::level_t      cir_vld,
	input  fetch_pkg::level_t      cir_use,
	input  logic                   cir_lock,
	output fetch_pkg::next_regs_t  next_regs
);

	logic              jump_now;
	logic              flushing;
	logic              unaligned_pending;
	logic              q_push;
	logic              q_pop;
	logic              q_empty;
	logic              q_full;
	logic              q_almost_full;
	logic              bypass_taken;
	fetch_pkg::word_t  q_head;
	fetch_pkg::word_t  next_instr;
	fetch_pkg::level_t level_next;

	// ------------------------------
	// bus side

	fetch_request i_fetch_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.jump_target       (jump_target),
		.jump_vld          (jump_vld),
		.jump_rdy          (jump_rdy),
		.mem_req           (mem_req),
		.mem_rdy           (mem_rdy),
		.mem_rsp_vld       (mem_rsp.vld),
		.q_full            (q_full),
		.q_almost_full     (q_almost_full),
		.jump_now          (jump_now),
		.flushing          (flushing),
		.unaligned_pending (unaligned_pending)
	);

	// only live data that did not go straight to the cir is queued
	assign q_push = mem_rsp.vld && !flushing && !bypass_taken;

	fetch_queue i_fetch_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (jump_now),
		.push        (q_push),
		.wdata       (mem_rsp.data),
		.pop         (q_pop),
		.head        (q_head),
		.empty       (q_empty),
		.full        (q_full),
		.almost_full (q_almost_full)
	);

	// ------------------------------
	// decode side

	instr_aligner i_instr_aligner (
		.clk               (clk),
		.rst_n             (rst_n),
		.jump_now          (jump_now),
		.flushing          (flushing),
		.unaligned_pending (unaligned_pending),
		.rsp               (mem_rsp),
		.q_head            (q_head),
		.q_empty           (q_empty),
		.pop               (q_pop),
		.bypass_taken      (bypass_taken),
		.cir               (cir),
		.cir_vld           (cir_vld),
		.cir_use           (cir_use),
		.cir_lock          (cir_lock),
		.next_instr        (next_instr),
		.level_next        (level_next)
	);

	reg_predecode i_reg_predecode (
		.next_instr (next_instr),
		.level_next (level_next),
		.next_regs  (next_regs)
	);

endmodule

`default_nettype wire

// File: fetch_frontend_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_asserts (
	input logic                   clk,
	input logic                   rst_n,
	input fetch_pkg::fetch_req_t  mem_req,
	input logic                   mem_rdy,
	input fetch_pkg::fetch_data_t mem_rsp,
	input fetch_pkg::level_t      cir_vld,
	input fetch_pkg::level_t      cir_use
);

	// accepted fetches not yet answered
	int outstanding;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(mem_req.vld && mem_rdy) - int'(mem_rsp.vld);
		end
	end

	// ------------------------------
	// bus and decode rules

	held_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req.vld && !mem_rdy) |=> (mem_req.vld && mem_req.addr == $past(mem_req.addr)))
		else $error("mem_req changed while its address phase was held");

	use_within_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld)
		else $error("cir_use exceeds cir_vld");

	rsp_has_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rsp.vld |-> (outstanding != 0))
		else $error("mem_rsp arrived with no fetch outstanding");

	// level 3 is internal only
	vld_at_most_two: assert property (@(posedge clk) disable iff (!rst_n)
		cir_vld <= 2'd2)
		else $error("cir_vld above two halfwords");

endmodule

bind fetch_frontend fetch_frontend_asserts i_fetch_frontend_asserts (
	.clk     (clk),
	.rst_n   (rst_n),
	.mem_req (mem_req),
	.mem_rdy (mem_rdy),
	.mem_rsp (mem_rsp),
	.cir_vld (cir_vld),
	.cir_use (cir_use)
);

`default_nettype wire

// File: tb_fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend;

	// instructions the decode model has to retire
	localparam int NUM_INSTR   = 400;
	localparam int MAX_CYCLES  = 20 * NUM_INSTR;
	localparam int HALF_PERIOD = 20;

	logic                   clk;
	logic                   rst_n;
	fetch_pkg::fetch_req_t  mem_req;
	logic                   mem_rdy;
	fetch_pkg::fetch_data_t mem_rsp;
	fetch_pkg::addr_t       jump_target;
	logic                   jump_vld;
	logic                   jump_rdy;
	fetch_pkg::word_t       cir;
	fetch_pkg::level_t      cir_vld;
	fetch_pkg::level_t      cir_use;
	logic                   cir_lock;
	fetch_pkg::next_regs_t  next_regs;

	logic [31:0]           lfsr_state;
	logic [31:0]           bits;
	// memory model queue of accepted fetches in request order
	fetch_pkg::addr_t      rsp_addr_q [$];
	int                    rsp_due_q [$];
	int                    last_due;
	int                    due;
	int                    cycle;
	int                    consumed;
	// instructions retired since the last jump
	int                    since_jump;
	// decode model program counter
	fetch_pkg::addr_t      pc;
	fetch_pkg::addr_t      held_addr;
	logic                  held;
	logic                  seen_first;
	logic                  lock_skip;
	logic                  regs_due;
	// no lock last cycle, so the cir moved on as predicted
	logic                  vld_due;
	logic                  exp_vld;
	fetch_pkg::word_t      locked_cir;
	fetch_pkg::level_t     locked_vld;
	fetch_pkg::level_t     len;
	fetch_pkg::word_t      expect_word;
	fetch_pkg::word_t      actual_word;
	fetch_pkg::hword_t     first_hw;
	fetch_pkg::next_regs_t regs_seen;
	logic [9:0]            exp_regs;

	fetch_frontend i_fetch_frontend (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_req     (mem_req),
		.mem_rdy     (mem_rdy),
		.mem_rsp     (mem_rsp),
		.jump_target (jump_target),
		.jump_vld    (jump_vld),
		.jump_rdy    (jump_rdy),
		.cir         (cir),
		.cir_vld     (cir_vld),
		.cir_use     (cir_use),
		.cir_lock    (cir_lock),
		.next_regs   (next_regs)
	);

	always #HALF_PERIOD clk = ~clk;

	// ------------------------------
	// helpers

	// right-shifting galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// one lfsr step per bit handed out
	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// memory contents are a hash of the word address
	function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t addr);
		logic [31:0] h;
		h = {2'b00, addr[31:2]} * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		h = h * 32'h85EB_CA6B;
		h = h ^ (h >> 13);
		return h;
	endfunction

	function automatic fetch_pkg::hword_t halfword_at(input fetch_pkg::addr_t addr);
		fetch_pkg::word_t w;
		w = mem_word({addr[31:2], 2'b00});
		return addr[1] ? w[31:16] : w[15:0];
	endfunction

	// source registers as {rs1, rs2}
	function automatic logic [9:0] expected_regs(input fetch_pkg::word_t instr);
		logic [1:0] quad;
		logic [2:0] f3;
		logic       sp_form;
		logic       wide_rs1;
		logic [4:0] rs1;
		logic [4:0] rs2;
		quad = instr[1:0];
		f3   = instr[15:13];
		if (quad == 2'b11) begin
			rs1 = instr[19:15];
			rs2 = instr[24:20];
		end else begin
			// addi4spn, addi16sp, lwsp and swsp go through sp
			sp_form = (quad == 2'b00 && f3 == 3'd0) || (quad == 2'b01 && f3 == 3'd3)
				|| (quad == 2'b10 && (f3 == 3'd2 || f3 == 3'd6));
			wide_rs1 = (quad == 2'b10) || (quad == 2'b01 && f3 == 3'd0);
			if (sp_form) begin
				rs1 = 5'd2;
			end else if (wide_rs1) begin
				rs1 = instr[11:7];
			end else begin
				rs1 = {2'b01, instr[9:7]};
			end
			rs2 = (quad == 2'b10) ? instr[6:2] : {2'b01, instr[4:2]};
		end
		return {rs1, rs2};
	endfunction

	task automatic end_with_failure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			end_with_failure($sformatf("[FAIL] %s: expected %h, actual %h",
				what, expected, actual));
		end
	endtask

	// ------------------------------
	// stimulus and checking

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		mem_rdy     = 1'b0;
		mem_rsp     = '0;
		jump_target = '0;
		jump_vld    = 1'b0;
		cir_use     = '0;
		cir_lock    = 1'b0;
		lfsr_state  = 32'd30;
		last_due    = 0;
		cycle       = 0;
		consumed    = 0;
		since_jump  = 0;
		pc          = fetch_pkg::RESET_VECTOR;
		held        = 1'b0;
		held_addr   = '0;
		seen_first  = 1'b0;
		lock_skip   = 1'b0;
		regs_due    = 1'b0;
		vld_due     = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		while (consumed < NUM_INSTR) begin
			if (cycle > MAX_CYCLES) begin
				end_with_failure($sformatf("timeout: only %0d of %0d instructions in %0d cycles",
					consumed, NUM_INSTR, MAX_CYCLES));
			end

			// predecode from last cycle must describe today's cir
			if (regs_due) begin
				exp_regs = expected_regs(cir);
				check_value("next_regs.rs1", 32'(exp_regs[9:5]), 32'(regs_seen.rs1));
				check_value("next_regs.rs2", 32'(exp_regs[4:0]), 32'(regs_seen.rs2));
			end
			// valid only once the cir holds the whole instruction
			if (vld_due) begin
				exp_vld = (cir_vld != 2'd0) && (cir[1:0] != 2'b11 || cir_vld == 2'd2);
				check_value("next_regs.vld", 32'(exp_vld), 32'(regs_seen.vld));
			end
			// jumps are refused only while an address phase is held
			check_value("jump_rdy", 32'(!held), 32'(jump_rdy));

			// memory data phase with at most one strobe per cycle
			mem_rsp = '0;
			if (rsp_addr_q.size() != 0 && rsp_due_q[0] <= cycle) begin
				mem_rsp.vld  = 1'b1;
				mem_rsp.data = mem_word(rsp_addr_q.pop_front());
				due = rsp_due_q.pop_front();
			end
			random_bits(2, bits);
			mem_rdy = bits[1:0] != 2'd0;

			// decode model
			cir_use  = '0;
			cir_lock = 1'b0;
			jump_vld = 1'b0;
			if (lock_skip) begin
				// cycle after a lock still shows the frozen instruction
				check_value("locked cir", locked_cir, cir);
				check_value("locked cir_vld", 32'(locked_vld), 32'(cir_vld));
				lock_skip = 1'b0;
			end else begin
				random_bits(4, bits);
				if (jump_rdy && since_jump != 0 && bits[3:0] == 4'd0) begin
					random_bits(15, bits);
					jump_target = 32'h0000_2000 + {16'h0, bits[14:0], 1'b0};
					jump_vld    = 1'b1;
					random_bits(1, bits);
					if (bits[0]) begin
						cir_lock   = 1'b1;
						locked_cir = cir;
						locked_vld = cir_vld;
						lock_skip  = 1'b1;
					end
					pc         = jump_target;
					since_jump = 0;
				end else begin
					first_hw = halfword_at(pc);
					len = (first_hw[1:0] == 2'b11) ? 2'd2 : 2'd1;
					random_bits(2, bits);
					if (cir_vld >= len && bits[1:0] != 2'd0) begin
						expect_word = (len == 2'd2) ? {halfword_at(pc + 32'd2), first_hw}
							: {16'h0, first_hw};
						actual_word = (len == 2'd2) ? cir : {16'h0, cir[15:0]};
						check_value($sformatf("instruction at %h", pc), expect_word, actual_word);
						cir_use    = len;
						pc         = pc + {29'd0, len, 1'b0};
						consumed   = consumed + 1;
						since_jump = since_jump + 1;
					end
				end
			end

			#1;
			// quiet outputs for the first cycle out of reset
			if (cycle == 0) begin
				check_value("mem_req.vld after reset", 32'd0, 32'(mem_req.vld));
				check_value("cir_vld after reset", 32'd0, 32'(cir_vld));
				check_value("next_regs.vld after reset", 32'd0, 32'(next_regs.vld));
			end
			if (held) begin
				check_value("held mem_req.vld", 32'd1, 32'(mem_req.vld));
				check_value("held mem_req.addr", held_addr, mem_req.addr);
			end
			if (mem_req.vld && !seen_first) begin
				check_value("first fetch address", fetch_pkg::RESET_VECTOR, mem_req.addr);
				seen_first = 1'b1;
			end
			held      = mem_req.vld && !mem_rdy;
			held_addr = mem_req.addr;
			// accepted at the coming edge with data one or two cycles later
			if (mem_req.vld && mem_rdy) begin
				random_bits(1, bits);
				due = cycle + 1 + int'(bits[0]);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				rsp_addr_q.push_back(mem_req.addr);
				rsp_due_q.push_back(due);
			end
			regs_due  = next_regs.vld && !jump_vld && !cir_lock;
			vld_due   = !cir_lock;
			regs_seen = next_regs;

			@(negedge clk);
			cycle = cycle + 1;
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
fetch_pkg.sv
fetch_queue.sv
fetch_request.sv
instr_aligner.sv
reg_predecode.sv
fetch_frontend.sv
fetch_frontend_asserts.sv
tb_fetch_frontend.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failures found" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
